// File: Makefile
TOP = tb_axi_write

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/10ps -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f list.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

// File: aw_address_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module aw_address_decoder
  import axi_pkg::*;
#(
  parameter logic [1:0] MASTER_NUM = 2'd1
) (
  input  logic       clk,
  input  logic       rstn,
  input  aw_req_m_t  aw_m,
  output logic       awready_m,
  output aw_req_s_t  aw_s0,
  output aw_req_s_t  aw_s1,
  output aw_req_s_t  aw_s2,
  input  logic       awready_s0,
  input  logic       awready_s1,
  input  logic       awready_s2,
  input  logic       w_last_done,
  input  logic       b_done,
  output slave_sel_t sel,
  output logic       route_valid
);

  slave_sel_t addr_sel;
  aw_req_s_t  aw_fwd;
  logic       sel_ready;
  logic       busy;
  logic       aw_fire;

  always_comb begin
    if ((aw_m.addr & REGION_MASK) == S0_BASE) begin
      addr_sel = SEL_S0;
    end else if ((aw_m.addr & REGION_MASK) == S1_BASE) begin
      addr_sel = SEL_S1;
    end else begin
      addr_sel = SEL_S2;
    end
  end

  assign aw_fwd = '{valid: aw_m.valid & ~busy,
                    id:    {MASTER_NUM, aw_m.id},
                    addr:  aw_m.addr,
                    len:   aw_m.len};

  // Valid only toward the decoded slave
  always_comb begin
    aw_s0       = aw_fwd;
    aw_s1       = aw_fwd;
    aw_s2       = aw_fwd;
    aw_s0.valid = aw_fwd.valid & (addr_sel == SEL_S0);
    aw_s1.valid = aw_fwd.valid & (addr_sel == SEL_S1);
    aw_s2.valid = aw_fwd.valid & (addr_sel == SEL_S2);
    case (addr_sel)
      SEL_S0:  sel_ready = awready_s0;
      SEL_S1:  sel_ready = awready_s1;
      default: sel_ready = awready_s2;
    endcase
  end

  assign awready_m = ~busy & sel_ready;
  assign aw_fire   = aw_m.valid & awready_m;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy        <= 1'b0;
      route_valid <= 1'b0;
      sel         <= SEL_S2;
    end else begin
      if (aw_fire) begin
        busy        <= 1'b1;
        route_valid <= 1'b1;
        sel         <= addr_sel;
      end else begin
        if (b_done) begin
          busy <= 1'b0;
        end
        // Route freed once the last beat is through
        if (w_last_done) begin
          route_valid <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: axi_define.svh
`ifndef AXI_DEFINE_SVH
`define AXI_DEFINE_SVH

// Master ID, and slave ID with the master number on top
`define AXI_ID_BITS  4
`define AXI_IDS_BITS 6

// Write response codes
`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10
`define AXI_RESP_DECERR 2'b11

`endif

// File: axi_pkg.sv
`default_nettype none

`include "axi_define.svh"

package axi_pkg;

  typedef logic [31:0]                addr_t;
  typedef logic [31:0]                data_t;
  typedef logic [7:0]                 len_t;
  typedef logic [`AXI_ID_BITS-1:0]    id_t;
  typedef logic [`AXI_IDS_BITS-1:0]   ids_t;
  typedef logic [1:0]                 resp_t;

  typedef struct packed {
    logic  valid;
    id_t   id;
    addr_t addr;
    len_t  len;
  } aw_req_m_t;

  typedef struct packed {
    logic  valid;
    ids_t  id;
    addr_t addr;
    len_t  len;
  } aw_req_s_t;

  typedef struct packed {
    logic  valid;
    data_t data;
    logic  last;
  } w_req_t;

  typedef struct packed {
    logic  valid;
    ids_t  ids;
    resp_t resp;
  } b_rsp_s_t;

  typedef enum logic [1:0] {SEL_S0, SEL_S1, SEL_S2} slave_sel_t;

  typedef enum logic [1:0] {LOCK_NO, LOCK_S0, LOCK_S1, LOCK_S2} data_arb_lock_t;

  typedef enum logic [1:0] {
    AXI_MASTER_0_ID,
    AXI_MASTER_1_ID,
    AXI_MASTER_2_ID,
    AXI_MASTER_U_ID
  } axi_master_id_t;

  // Address map, 64 KB regions
  localparam addr_t S0_BASE     = 32'h0000_0000;
  localparam addr_t S1_BASE     = 32'h0001_0000;
  localparam addr_t REGION_MASK = 32'hFFFF_0000;

  // Master number sits in the top two ID bits
  function automatic axi_master_id_t DATA_DECODER(input ids_t ids);
    case (ids[`AXI_IDS_BITS-1:`AXI_ID_BITS])
      2'd0:    return AXI_MASTER_0_ID;
      2'd1:    return AXI_MASTER_1_ID;
      2'd2:    return AXI_MASTER_2_ID;
      default: return AXI_MASTER_U_ID;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: axi_write_properties.sv
`timescale 1ns/10ps
`default_nettype none

module axi_write_properties
  import axi_pkg::*;
(
  input logic      clk,
  input logic      rstn,
  input aw_req_m_t aw_m,
  input logic      awready_m,
  input w_req_t    w_m,
  input logic      wready_m,
  input b_rsp_s_t  b_m,
  input logic      bready_m
);

  logic busy;
  logic w_last_seen;

  // Write window seen from the master ports
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy        <= 1'b0;
      w_last_seen <= 1'b0;
    end else begin
      if (aw_m.valid && awready_m) begin
        busy <= 1'b1;
      end else if (b_m.valid && bready_m) begin
        busy <= 1'b0;
      end
      if (w_m.valid && wready_m && w_m.last) begin
        w_last_seen <= 1'b1;
      end else if (b_m.valid && bready_m) begin
        w_last_seen <= 1'b0;
      end
    end
  end

  aw_stable: assert property (@(posedge clk) disable iff (!rstn)
    aw_m.valid && !awready_m |=> aw_m.valid && $stable(aw_m))
    else $error("AW request changed while stalled");

  w_stable: assert property (@(posedge clk) disable iff (!rstn)
    w_m.valid && !wready_m |=> w_m.valid && $stable(w_m))
    else $error("W beat changed while stalled");

  b_stable: assert property (@(posedge clk) disable iff (!rstn)
    b_m.valid && !bready_m |=> b_m.valid && $stable(b_m))
    else $error("B response changed while stalled");

  b_after_w: assert property (@(posedge clk) disable iff (!rstn)
    $rose(b_m.valid) |-> w_last_seen)
    else $error("B response without a last W beat");

  aw_blocked: assert property (@(posedge clk) disable iff (!rstn)
    busy |-> !awready_m)
    else $error("AW ready while a write is in flight");

endmodule

bind axi_write_top axi_write_properties u_props (
  .clk, .rstn, .aw_m, .awready_m, .w_m, .wready_m, .b_m, .bready_m
);

`default_nettype wire

// File: axi_write_top.sv
`timescale 1ns/10ps
`default_nettype none

module axi_write_top
  import axi_pkg::*;
#(
  parameter logic [1:0] MASTER_NUM = 2'd1
) (
  input  logic      clk,
  input  logic      rstn,
  input  aw_req_m_t aw_m,
  output logic      awready_m,
  input  w_req_t    w_m,
  output logic      wready_m,
  output b_rsp_s_t  b_m,
  input  logic      bready_m
);

  aw_req_s_t  aw_s0, aw_s1, aw_s2;
  logic       awready_s0, awready_s1, awready_s2;
  w_req_t     w_s0, w_s1, w_s2;
  logic       wready_s0, wready_s1, wready_s2;
  b_rsp_s_t   b_s0, b_s1, b_s2;
  logic       bready_s0, bready_s1, bready_s2;
  slave_sel_t sel;
  logic       route_valid;
  logic       w_last_done;

  aw_address_decoder #(.MASTER_NUM(MASTER_NUM)) u_aw_dec (
    .clk, .rstn, .aw_m, .awready_m,
    .aw_s0, .aw_s1, .aw_s2, .awready_s0, .awready_s1, .awready_s2,
    .w_last_done, .b_done(b_m.valid & bready_m), .sel, .route_valid
  );

  w_data_router u_w_router (
    .clk, .rstn, .w_m, .wready_m, .sel, .route_valid,
    .w_s0, .w_s1, .w_s2, .wready_s0, .wready_s1, .wready_s2, .w_last_done
  );

  b_response_mux u_b_mux (
    .clk, .rstn, .b_m1(b_m), .bready_m1(bready_m),
    .w_m_valid(w_m.valid), .w_m_ready(wready_m), .w_m_last(w_m.last),
    .b_s0, .b_s1, .b_s2, .bready_s0, .bready_s1, .bready_s2
  );

  slave_write_endpoint #(.RESP_ALWAYS(1'b0)) u_slave0 (
    .clk, .rstn, .aw(aw_s0), .awready(awready_s0), .w(w_s0), .wready(wready_s0),
    .b_rsp(b_s0), .bready(bready_s0)
  );

  slave_write_endpoint #(.RESP_ALWAYS(1'b0)) u_slave1 (
    .clk, .rstn, .aw(aw_s1), .awready(awready_s1), .w(w_s1), .wready(wready_s1),
    .b_rsp(b_s1), .bready(bready_s1)
  );

  // Default slave for unmapped addresses
  slave_write_endpoint #(.RESP_ALWAYS(1'b1)) u_slave2 (
    .clk, .rstn, .aw(aw_s2), .awready(awready_s2), .w(w_s2), .wready(wready_s2),
    .b_rsp(b_s2), .bready(bready_s2)
  );

endmodule

`default_nettype wire

// File: b_response_mux.sv
`timescale 1ns/10ps
`default_nettype none

`include "axi_define.svh"

module b_response_mux
  import axi_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  output b_rsp_s_t b_m1,
  input  logic     bready_m1,
  input  logic     w_m_valid,
  input  logic     w_m_ready,
  input  logic     w_m_last,
  input  b_rsp_s_t b_s0,
  input  b_rsp_s_t b_s1,
  input  b_rsp_s_t b_s2,
  output logic     bready_s0,
  output logic     bready_s1,
  output logic     bready_s2
);

  data_arb_lock_t lock_q;
  data_arb_lock_t lock_d;
  b_rsp_s_t       b_sel;
  logic           bready_from_m;
  logic           b_enable;
  axi_master_id_t decode_result;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lock_q <= LOCK_NO;
    end else begin
      lock_q <= lock_d;
    end
  end

  // Armed by the last W handshake, dropped once a slave answers
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      b_enable <= 1'b0;
    end else if (b_enable) begin
      if (b_s0.valid | b_s1.valid | b_s2.valid) begin
        b_enable <= 1'b0;
      end
    end else if (w_m_valid & w_m_ready & w_m_last) begin
      b_enable <= 1'b1;
    end
  end

  // Round-robin from the slave just served
  always_comb begin
    lock_d = lock_q;
    case (lock_q)
      LOCK_S0: begin
        if (bready_from_m) begin
          if (b_s1.valid) lock_d = LOCK_S1;
          else if (b_s2.valid) lock_d = LOCK_S2;
          else lock_d = LOCK_NO;
        end
      end
      LOCK_S1: begin
        if (bready_from_m) begin
          if (b_s2.valid) lock_d = LOCK_S2;
          else if (b_s0.valid) lock_d = LOCK_S0;
          else lock_d = LOCK_NO;
        end
      end
      LOCK_S2: begin
        if (bready_from_m) begin
          if (b_s0.valid) lock_d = LOCK_S0;
          else if (b_s1.valid) lock_d = LOCK_S1;
          else lock_d = LOCK_NO;
        end
      end
      default: begin
        if (b_enable) begin
          if (b_s0.valid) lock_d = LOCK_S0;
          else if (b_s1.valid) lock_d = LOCK_S1;
          else if (b_s2.valid) lock_d = LOCK_S2;
        end
      end
    endcase
  end

  always_comb begin
    b_sel     = '{valid: 1'b0, ids: '0, resp: `AXI_RESP_SLVERR};
    bready_s0 = 1'b0;
    bready_s1 = 1'b0;
    bready_s2 = 1'b0;
    case (lock_q)
      LOCK_S0: begin
        b_sel     = b_s0;
        bready_s0 = bready_from_m;
      end
      LOCK_S1: begin
        b_sel     = b_s1;
        bready_s1 = bready_from_m;
      end
      LOCK_S2: begin
        b_sel     = b_s2;
        bready_s2 = bready_from_m;
      end
      default: ;
    endcase
  end

  assign decode_result = DATA_DECODER(b_sel.ids);

  // Only master 1 is wired, other IDs are held off
  always_comb begin
    b_m1          = '{valid: 1'b0, ids: '0, resp: `AXI_RESP_SLVERR};
    bready_from_m = 1'b0;
    case (decode_result)
      AXI_MASTER_1_ID: begin
        b_m1.valid    = b_sel.valid;
        b_m1.ids      = {{(`AXI_IDS_BITS-`AXI_ID_BITS){1'b0}},
                         b_sel.ids[`AXI_ID_BITS-1:0]};
        b_m1.resp     = b_sel.resp;
        bready_from_m = bready_m1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
axi_pkg.sv
aw_address_decoder.sv
w_data_router.sv
b_response_mux.sv
slave_write_endpoint.sv
axi_write_top.sv
axi_write_properties.sv
tb_axi_write.sv

// File: slave_write_endpoint.sv
`timescale 1ns/10ps
`default_nettype none

`include "axi_define.svh"

module slave_write_endpoint
  import axi_pkg::*;
#(
  parameter bit RESP_ALWAYS = 1'b0
) (
  input  logic      clk,
  input  logic      rstn,
  input  aw_req_s_t aw,
  output logic      awready,
  input  w_req_t    w,
  output logic      wready,
  output b_rsp_s_t  b_rsp,
  input  logic      bready
);

  typedef enum logic [1:0] {ST_IDLE, ST_DATA, ST_RESP} ep_state_t;

  ep_state_t state;
  ids_t      id_q;
  len_t      len_q;
  len_t      beat_cnt;
  logic      overrun;
  resp_t     resp_q;

  assign awready = (state == ST_IDLE);
  assign wready  = (state == ST_DATA);
  assign b_rsp   = '{valid: (state == ST_RESP), ids: id_q, resp: resp_q};

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state    <= ST_IDLE;
      beat_cnt <= '0;
      overrun  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (aw.valid) begin
            beat_cnt <= '0;
            overrun  <= 1'b0;
            state    <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (w.valid) begin
            if (w.last) begin
              state <= ST_RESP;
            end else begin
              // Last expected beat went by without WLAST
              if (beat_cnt == len_q) begin
                overrun <= 1'b1;
              end
              beat_cnt <= beat_cnt + 8'd1;
            end
          end
        end
        ST_RESP: begin
          if (bready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && aw.valid) begin
      id_q  <= aw.id;
      len_q <= aw.len;
    end
    if (state == ST_DATA && w.valid && w.last) begin
      if (RESP_ALWAYS) begin
        resp_q <= `AXI_RESP_DECERR;
      end else if (overrun || beat_cnt != len_q) begin
        resp_q <= `AXI_RESP_SLVERR;
      end else begin
        resp_q <= `AXI_RESP_OKAY;
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_axi_write.sv
`timescale 1ns/10ps
`default_nettype none

`include "axi_define.svh"

module tb_axi_write
  import axi_pkg::*;
();

  localparam int NUM_ROWS = 9;
  localparam int TIMEOUT  = 50;

  typedef struct packed {
    addr_t addr;
    id_t   id;
    len_t  len;
    int    beats;
    resp_t resp;
    logic  offer_next;
  } row_t;

  logic      clk;
  logic      rstn;
  aw_req_m_t aw_m;
  logic      awready_m;
  w_req_t    w_m;
  logic      wready_m;
  b_rsp_s_t  b_m;
  logic      bready_m;

  row_t        rows [NUM_ROWS];
  logic [31:0] lfsr;
  logic        aw_offered;

  axi_write_top #(.MASTER_NUM(2'd1)) dut (
    .clk, .rstn, .aw_m, .awready_m, .w_m, .wready_m, .b_m, .bready_m
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("Verification failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic abort_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("Verification failed");
    $fatal(1, "Wait loop expired");
  endtask

  task automatic load_rows();
    // addr, id, len, beats sent, expected resp, offer next AW while busy
    rows[0] = '{32'h0000_0040, 4'h3, 8'd3, 4, `AXI_RESP_OKAY,   1'b0};
    rows[1] = '{32'h0001_0010, 4'hA, 8'd1, 2, `AXI_RESP_OKAY,   1'b0};
    rows[2] = '{32'h0002_0000, 4'h5, 8'd0, 1, `AXI_RESP_DECERR, 1'b0};
    rows[3] = '{32'h0000_0100, 4'h7, 8'd3, 2, `AXI_RESP_SLVERR, 1'b0};
    rows[4] = '{32'h0001_0020, 4'hC, 8'd1, 4, `AXI_RESP_SLVERR, 1'b0};
    rows[5] = '{32'h0000_0200, 4'hF, 8'd0, 1, `AXI_RESP_OKAY,   1'b1};
    rows[6] = '{32'h0001_0000, 4'h1, 8'd2, 3, `AXI_RESP_OKAY,   1'b1};
    rows[7] = '{32'h8000_0000, 4'h9, 8'd1, 2, `AXI_RESP_DECERR, 1'b0};
    rows[8] = '{32'h0000_FFFC, 4'h0, 8'd7, 8, `AXI_RESP_OKAY,   1'b0};
  endtask

  task automatic run_write(input int idx);
    row_t       r;
    row_t       nr;
    int         cnt;
    int         beat;
    int         k;
    logic [2:0] stall;
    b_rsp_s_t   held;
    r = rows[idx];
    if (!aw_offered) begin
      aw_m <= '{valid: 1'b1, id: r.id, addr: r.addr, len: r.len};
    end
    aw_offered = 1'b0;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt = cnt + 1;
      // No stray response between writes
      check_value("b_m.valid", 32'(b_m.valid), 32'd0);
      if (cnt > TIMEOUT) abort_timeout("awready_m");
    end while (!awready_m);
    if (r.offer_next && idx + 1 < NUM_ROWS) begin
      nr = rows[idx + 1];
      aw_m <= '{valid: 1'b1, id: nr.id, addr: nr.addr, len: nr.len};
      aw_offered = 1'b1;
    end else begin
      aw_m.valid <= 1'b0;
    end
    for (beat = 0; beat < r.beats; beat++) begin
      w_m <= '{valid: 1'b1, data: {idx[15:0], beat[15:0]}, last: (beat == r.beats - 1)};
      cnt = 0;
      do begin
        @(posedge clk);
        cnt = cnt + 1;
        check_value("awready_m", 32'(awready_m), 32'd0);
        if (cnt > TIMEOUT) abort_timeout("wready_m");
      end while (!wready_m);
    end
    w_m.valid <= 1'b0;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt = cnt + 1;
      check_value("awready_m", 32'(awready_m), 32'd0);
      if (cnt > TIMEOUT) abort_timeout("b_m.valid");
    end while (!b_m.valid);
    check_value("bvalid latency", 32'(cnt), 32'd2);
    stall = '0;
    for (k = 0; k < 3; k++) begin
      lfsr  = lfsr_step(lfsr);
      stall = {stall[1:0], lfsr[0]};
    end
    held = b_m;
    repeat (stall) begin
      @(posedge clk);
      check_value("b_m", 32'(b_m), 32'(held));
      check_value("awready_m", 32'(awready_m), 32'd0);
    end
    bready_m <= 1'b1;
    @(posedge clk);
    check_value("b_m.valid", 32'(b_m.valid), 32'd1);
    check_value("awready_m", 32'(awready_m), 32'd0);
    bready_m <= 1'b0;
    // Upper ID bits are cleared toward the master
    check_value("b_m.ids", 32'(b_m.ids), 32'(r.id));
    check_value("b_m.resp", 32'(b_m.resp), 32'(r.resp));
  endtask

  initial begin
    int n;
    rstn        = 1'b0;
    aw_m        = '0;
    w_m         = '0;
    bready_m    = 1'b0;
    lfsr        = 32'h71c1;
    aw_offered  = 1'b0;
    load_rows();
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    check_value("wready_m", 32'(wready_m), 32'd0);
    check_value("b_m.valid", 32'(b_m.valid), 32'd0);
    for (n = 0; n < NUM_ROWS; n++) begin
      run_write(n);
    end
    @(posedge clk);
    check_value("b_m.valid", 32'(b_m.valid), 32'd0);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: w_data_router.sv
`timescale 1ns/10ps
`default_nettype none

module w_data_router
  import axi_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  w_req_t     w_m,
  output logic       wready_m,
  input  slave_sel_t sel,
  input  logic       route_valid,
  output w_req_t     w_s0,
  output w_req_t     w_s1,
  output w_req_t     w_s2,
  input  logic       wready_s0,
  input  logic       wready_s1,
  input  logic       wready_s2,
  output logic       w_last_done
);

  logic w_open;
  logic sel_ready;

  // Closed in the cycle of the done pulse, before the route drops
  assign w_open = route_valid & ~w_last_done;

  always_comb begin
    w_s0       = w_m;
    w_s1       = w_m;
    w_s2       = w_m;
    w_s0.valid = w_open & w_m.valid & (sel == SEL_S0);
    w_s1.valid = w_open & w_m.valid & (sel == SEL_S1);
    w_s2.valid = w_open & w_m.valid & (sel == SEL_S2);
    case (sel)
      SEL_S0:  sel_ready = wready_s0;
      SEL_S1:  sel_ready = wready_s1;
      default: sel_ready = wready_s2;
    endcase
  end

  assign wready_m = w_open & sel_ready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      w_last_done <= 1'b0;
    end else begin
      w_last_done <= w_m.valid & wready_m & w_m.last;
    end
  end

endmodule

`default_nettype wire
